// File: Bender.yml
package:
  name: aes_round_ctrl

sources:
  # Packages first, then rails, guard and top
  - hdl/aes_sp_pkg.sv
  - hdl/aes_ciph_pkg.sv
  - hdl/aes_round_rail.sv
  - hdl/aes_ctrl_guard.sv
  - hdl/aes_round_ctrl.sv

  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_aes_round_ctrl.sv

// File: hdl/aes_ciph_pkg.sv
//////////////////////////////////////////////////
// Cipher control types, round count rule and the
// per-rail input and output bundles
//////////////////////////////////////////////////

`default_nettype none

package aes_ciph_pkg;

  // Round counter width, holds 0 to 14
  parameter int unsigned RndCtrWidth = 4;

  //////////////////////////////////////////////////
  // Configuration and selector encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef enum logic [1:0] {
    STATE_INIT  = 2'b01, // Load input block
    STATE_ROUND = 2'b10  // Feed back round output
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100 // Last round skips mix columns
  } add_rk_sel_e;

  // Nr for a key length, illegal codes fall back to the longest schedule
  function automatic logic [RndCtrWidth-1:0] num_rounds(key_len_e key_len);
    logic [RndCtrWidth-1:0] nr;
    case (key_len)
      AES_128: nr = RndCtrWidth'(10);
      AES_192: nr = RndCtrWidth'(12);
      default: nr = RndCtrWidth'(14);
    endcase
    return nr;
  endfunction

  //////////////////////////////////////////////////
  // Rail bundles
  //////////////////////////////////////////////////

  // Handshake bits in the rail's own polarity
  typedef struct packed {
    logic in_valid;
    logic out_ready;
    logic crypt;
  } rail_in_t;

  typedef struct packed {
    logic                   in_ready;  // Rail polarity
    logic                   out_valid; // Rail polarity
    logic                   state_we;  // Rail polarity
    state_sel_e             state_sel;
    add_rk_sel_e            add_rk_sel;
    ciph_op_e               op;
    logic [RndCtrWidth-1:0] rnd_ctr;
    logic                   alert;
  } rail_out_t;

endpackage

`default_nettype wire

// File: hdl/aes_ctrl_guard.sv
//////////////////////////////////////////////////
// Sparse input checker and rail output merger,
// raises a fault on bad codes or rail divergence
//////////////////////////////////////////////////

`default_nettype none

module aes_ctrl_guard (
  input  aes_sp_pkg::sp2v_e                     in_valid_i,
  input  aes_sp_pkg::sp2v_e                     out_ready_i,
  input  aes_sp_pkg::sp2v_e                     crypt_i,
  input  logic                                  alert_fatal_i,

  input  aes_ciph_pkg::rail_out_t               rail_p_i,
  input  aes_ciph_pkg::rail_out_t               rail_n_i,
  output aes_ciph_pkg::rail_in_t                rail_p_o,
  output aes_ciph_pkg::rail_in_t                rail_n_o,
  output logic                                  fault_o,

  output aes_sp_pkg::sp2v_e                     in_ready_o,
  output aes_sp_pkg::sp2v_e                     out_valid_o,
  output aes_sp_pkg::sp2v_e                     state_we_o,
  output aes_ciph_pkg::state_sel_e              state_sel_o,
  output aes_ciph_pkg::add_rk_sel_e             add_rk_sel_o,
  output aes_ciph_pkg::ciph_op_e                key_expand_op_o,
  output logic [aes_ciph_pkg::RndCtrWidth-1:0]  key_expand_round_o,
  output logic                                  alert_o
);

  localparam int unsigned SpW = aes_sp_pkg::Sp2VWidth;

  // High when a level is not one of the two legal codes
  function automatic logic sp2v_bad(aes_sp_pkg::sp2v_e lvl);
    return !(lvl inside {aes_sp_pkg::SP2V_HIGH, aes_sp_pkg::SP2V_LOW});
  endfunction

  logic [2:0]     enc_err;
  logic [SpW-1:0] in_valid, out_ready, crypt;
  logic           mr_err;
  logic           hs_err;

  //////////////////////////////////////////////////
  // Input check and split
  //////////////////////////////////////////////////

  assign enc_err[0] = sp2v_bad(in_valid_i);
  assign enc_err[1] = sp2v_bad(out_ready_i);
  assign enc_err[2] = sp2v_bad(crypt_i);

  // Bad codes reach the rails as LOW
  assign in_valid  = enc_err[0] ? aes_sp_pkg::SP2V_LOW : in_valid_i;
  assign out_ready = enc_err[1] ? aes_sp_pkg::SP2V_LOW : out_ready_i;
  assign crypt     = enc_err[2] ? aes_sp_pkg::SP2V_LOW : crypt_i;

  assign rail_p_o.in_valid  = in_valid[0];
  assign rail_p_o.out_ready = out_ready[0];
  assign rail_p_o.crypt     = crypt[0];

  assign rail_n_o.in_valid  = in_valid[1];
  assign rail_n_o.out_ready = out_ready[1];
  assign rail_n_o.crypt     = crypt[1];

  //////////////////////////////////////////////////
  // Output merge
  //////////////////////////////////////////////////

  // Sparse outputs rebuilt from one bit per rail
  assign in_ready_o  = aes_sp_pkg::sp2v_e'({rail_n_i.in_ready, rail_p_i.in_ready});
  assign out_valid_o = aes_sp_pkg::sp2v_e'({rail_n_i.out_valid, rail_p_i.out_valid});
  assign state_we_o  = aes_sp_pkg::sp2v_e'({rail_n_i.state_we, rail_p_i.state_we});

  // OR merge, a diverging rail shows up in the compare below
  assign state_sel_o = aes_ciph_pkg::state_sel_e'(rail_p_i.state_sel | rail_n_i.state_sel);
  assign add_rk_sel_o =
      aes_ciph_pkg::add_rk_sel_e'(rail_p_i.add_rk_sel | rail_n_i.add_rk_sel);
  assign key_expand_op_o    = aes_ciph_pkg::ciph_op_e'(rail_p_i.op | rail_n_i.op);
  assign key_expand_round_o = rail_p_i.rnd_ctr | rail_n_i.rnd_ctr;

  always_comb begin
    mr_err = 1'b0;
    if (state_sel_o != rail_p_i.state_sel || state_sel_o != rail_n_i.state_sel) begin
      mr_err = 1'b1;
    end
    if (add_rk_sel_o != rail_p_i.add_rk_sel || add_rk_sel_o != rail_n_i.add_rk_sel) begin
      mr_err = 1'b1;
    end
    if (key_expand_op_o != rail_p_i.op || key_expand_op_o != rail_n_i.op) begin
      mr_err = 1'b1;
    end
    if (key_expand_round_o != rail_p_i.rnd_ctr ||
        key_expand_round_o != rail_n_i.rnd_ctr) begin
      mr_err = 1'b1;
    end
  end

  // Handshake bits of the two rails must always be opposite
  assign hs_err = (rail_p_i.in_ready == rail_n_i.in_ready) ||
                  (rail_p_i.out_valid == rail_n_i.out_valid) ||
                  (rail_p_i.state_we == rail_n_i.state_we);

  assign fault_o = (|enc_err) | mr_err | hs_err | alert_fatal_i;
  assign alert_o = rail_p_i.alert | rail_n_i.alert;

endmodule

`default_nettype wire

// File: hdl/aes_round_ctrl.sv
//////////////////////////////////////////////////
// AES round controller top, two redundant rails
// of opposite polarity behind a common guard
//////////////////////////////////////////////////

`default_nettype none

module aes_round_ctrl #(
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Block handshake
  input  aes_sp_pkg::sp2v_e                     in_valid_i,
  output aes_sp_pkg::sp2v_e                     in_ready_o,
  output aes_sp_pkg::sp2v_e                     out_valid_o,
  input  aes_sp_pkg::sp2v_e                     out_ready_i,

  // Configuration, sampled at acceptance
  input  aes_sp_pkg::sp2v_e                     crypt_i,
  input  aes_ciph_pkg::ciph_op_e                op_i,
  input  aes_ciph_pkg::key_len_e                key_len_i,
  input  logic                                  alert_fatal_i,
  output logic                                  alert_o,

  // Data path and key expand control
  output aes_sp_pkg::sp2v_e                     state_we_o,
  output aes_ciph_pkg::state_sel_e              state_sel_o,
  output aes_ciph_pkg::add_rk_sel_e             add_rk_sel_o,
  output aes_ciph_pkg::ciph_op_e                key_expand_op_o,
  output logic [aes_ciph_pkg::RndCtrWidth-1:0]  key_expand_round_o
);

  aes_ciph_pkg::rail_in_t  rail_in_p, rail_in_n;
  aes_ciph_pkg::rail_out_t rail_out_p, rail_out_n;
  logic                    fault;

  // True polarity rail, drives bit 0 of every sparse level
  aes_round_rail #(
    .ActiveLow     ( 1'b0          ),
    .CiphOpFwdOnly ( CiphOpFwdOnly )
  ) u_rail_p (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .rail_i    ( rail_in_p  ),
    .op_i      ( op_i       ),
    .key_len_i ( key_len_i  ),
    .fault_i   ( fault      ),
    .rail_o    ( rail_out_p )
  );

  // Inverted rail, drives bit 1
  aes_round_rail #(
    .ActiveLow     ( 1'b1          ),
    .CiphOpFwdOnly ( CiphOpFwdOnly )
  ) u_rail_n (
    .clk_i     ( clk_i      ),
    .rst_ni    ( rst_ni     ),
    .rail_i    ( rail_in_n  ),
    .op_i      ( op_i       ),
    .key_len_i ( key_len_i  ),
    .fault_i   ( fault      ),
    .rail_o    ( rail_out_n )
  );

  aes_ctrl_guard u_guard (
    .in_valid_i         ( in_valid_i         ),
    .out_ready_i        ( out_ready_i        ),
    .crypt_i            ( crypt_i            ),
    .alert_fatal_i      ( alert_fatal_i      ),
    .rail_p_i           ( rail_out_p         ),
    .rail_n_i           ( rail_out_n         ),
    .rail_p_o           ( rail_in_p          ),
    .rail_n_o           ( rail_in_n          ),
    .fault_o            ( fault              ), // Back to both rails
    .in_ready_o         ( in_ready_o         ),
    .out_valid_o        ( out_valid_o        ),
    .state_we_o         ( state_we_o         ),
    .state_sel_o        ( state_sel_o        ),
    .add_rk_sel_o       ( add_rk_sel_o       ),
    .key_expand_op_o    ( key_expand_op_o    ),
    .key_expand_round_o ( key_expand_round_o ),
    .alert_o            ( alert_o            )
  );

endmodule

`default_nettype wire

// File: hdl/aes_round_rail.sv
//////////////////////////////////////////////////
// One control rail of the round controller, FSM
// and round counter kept in a selectable polarity
//////////////////////////////////////////////////

`default_nettype none

module aes_round_rail #(
  parameter bit ActiveLow     = 1'b0,
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  aes_ciph_pkg::rail_in_t  rail_i,
  input  aes_ciph_pkg::ciph_op_e  op_i,
  input  aes_ciph_pkg::key_len_e  key_len_i,
  input  logic                    fault_i,
  output aes_ciph_pkg::rail_out_t rail_o
);

  localparam int unsigned CtrW = aes_ciph_pkg::RndCtrWidth;

  // Five of eight codes used, the rest decode to ERROR
  typedef enum logic [2:0] {
    IDLE  = 3'b011,
    INIT  = 3'b101,
    ROUND = 3'b110,
    DONE  = 3'b000,
    ERROR = 3'b111
  } state_e;

  // Storage masks, all ones on the inverted rail
  localparam logic [2:0]      StMask  = {3{ActiveLow}};
  localparam logic [CtrW-1:0] CtrMask = {CtrW{ActiveLow}};

  logic                   in_valid;
  logic                   out_ready;
  logic                   crypt;
  logic [2:0]             state_raw_d, state_raw_q;
  state_e                 state_d, state_q;
  logic [CtrW-1:0]        rnd_ctr_raw_q;
  logic [CtrW-1:0]        rnd_ctr_d, rnd_ctr_q;
  logic [CtrW-1:0]        nr_d, nr_q;
  aes_ciph_pkg::ciph_op_e op_d, op_q;
  logic                   last_rnd;
  logic                   in_ready;
  logic                   out_valid;
  logic                   state_we;

  // Back to true polarity for the FSM
  assign in_valid  = rail_i.in_valid ^ ActiveLow;
  assign out_ready = rail_i.out_ready ^ ActiveLow;
  assign crypt     = rail_i.crypt ^ ActiveLow;

  assign state_q   = state_e'(state_raw_q ^ StMask);
  assign rnd_ctr_q = rnd_ctr_raw_q ^ CtrMask;
  assign last_rnd  = (rnd_ctr_q == nr_q);

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    op_d      = op_q;
    nr_d      = nr_q;

    case (state_q)
      IDLE: begin
        if (in_valid && crypt) begin
          state_d   = INIT;
          rnd_ctr_d = '0;
          op_d      = CiphOpFwdOnly ? aes_ciph_pkg::CIPH_FWD : op_i;
          nr_d      = aes_ciph_pkg::num_rounds(key_len_i);
        end
      end
      INIT: begin
        state_d   = ROUND;
        rnd_ctr_d = rnd_ctr_q + 1'b1; // Round 1 next
      end
      ROUND: begin
        if (last_rnd) begin
          state_d = DONE; // Counter stays at Nr
        end else begin
          rnd_ctr_d = rnd_ctr_q + 1'b1;
        end
      end
      DONE: begin
        if (out_ready) begin
          state_d   = IDLE;
          rnd_ctr_d = '0;
        end
      end
      ERROR:   state_d = ERROR; // Terminal until reset
      default: state_d = ERROR;
    endcase

    // Any fault overrides the regular flow
    if (fault_i) begin
      state_d   = ERROR;
      rnd_ctr_d = '0;
    end
  end

  assign state_raw_d = state_d ^ StMask;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_raw_q   <= IDLE ^ StMask;
      rnd_ctr_raw_q <= CtrMask;
      op_q          <= aes_ciph_pkg::CIPH_FWD;
      nr_q          <= aes_ciph_pkg::num_rounds(aes_ciph_pkg::AES_128);
    end else begin
      state_raw_q   <= state_raw_d;
      rnd_ctr_raw_q <= rnd_ctr_d ^ CtrMask;
      op_q          <= op_d;
      nr_q          <= nr_d;
    end
  end

  //////////////////////////////////////////////////
  // Moore outputs
  //////////////////////////////////////////////////

  assign in_ready  = (state_q == IDLE);
  assign out_valid = (state_q == DONE);
  assign state_we  = (state_q == INIT) || (state_q == ROUND);

  always_comb begin
    rail_o.state_sel  = aes_ciph_pkg::STATE_INIT;
    rail_o.add_rk_sel = aes_ciph_pkg::ADD_RK_INIT;
    if (state_q == ROUND || state_q == DONE) begin
      rail_o.state_sel  = aes_ciph_pkg::STATE_ROUND;
      rail_o.add_rk_sel = last_rnd ? aes_ciph_pkg::ADD_RK_FINAL : aes_ciph_pkg::ADD_RK_ROUND;
    end
  end

  assign rail_o.in_ready  = in_ready ^ ActiveLow;
  assign rail_o.out_valid = out_valid ^ ActiveLow;
  assign rail_o.state_we  = state_we ^ ActiveLow;
  assign rail_o.op        = op_q;
  assign rail_o.rnd_ctr   = rnd_ctr_q;
  assign rail_o.alert     = (state_q == ERROR);

endmodule

`default_nettype wire

// File: hdl/aes_sp_pkg.sv
//////////////////////////////////////////////////
// Two-bit sparse level encoding for handshakes
// shared between the redundant control rails
//////////////////////////////////////////////////

`default_nettype none

package aes_sp_pkg;

  //////////////////////////////////////////////////
  // Sparse level
  //////////////////////////////////////////////////

  // Width of one sparse level
  parameter int unsigned Sp2VWidth = 2;

  // Bit 0 is carried by the true-polarity rail,
  // bit 1 by the inverted rail. A legal level has
  // exactly one bit set, so a stuck or flipped bit
  // always lands on one of the two illegal codes
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 2'b01, // True rail 1, inverted rail 0
    SP2V_LOW  = 2'b10  // True rail 0, inverted rail 1
  } sp2v_e;

  // Codes 2'b00 and 2'b11 are never driven on purpose.
  // The guard treats either one as an encoding error
  // and sends both rails into the terminal error state.

endpackage

`default_nettype wire

// File: sim.f
hdl/aes_sp_pkg.sv
hdl/aes_ciph_pkg.sv
hdl/aes_round_rail.sv
hdl/aes_ctrl_guard.sv
hdl/aes_round_ctrl.sv
test/tb_clk_gen.sv
test/tb_aes_round_ctrl.sv

// File: test/tb_aes_round_ctrl.sv
//////////////////////////////////////////////////
// Random block traffic, back-pressure and faults
// on the round controller against a cycle model
//////////////////////////////////////////////////

`default_nettype none

module tb_aes_round_ctrl;

  localparam int     NumOps    = 40;
  localparam int     NumFaults = 12;
  localparam int     MaxDelay  = 12; // Idle gap, crypt LOW and back-pressure together
  localparam int     Period    = 20;
  localparam longint Timeout   = (NumOps + NumFaults) * (16 + MaxDelay) * Period
                                 + 200 * Period;

  localparam aes_sp_pkg::sp2v_e High = aes_sp_pkg::SP2V_HIGH;
  localparam aes_sp_pkg::sp2v_e Low  = aes_sp_pkg::SP2V_LOW;

  typedef enum logic [2:0] {M_IDLE, M_INIT, M_ROUND, M_DONE, M_ERROR} model_state_e;

  // Everything the testbench drives into the DUT
  typedef struct packed {
    aes_sp_pkg::sp2v_e      in_valid;
    aes_sp_pkg::sp2v_e      out_ready;
    aes_sp_pkg::sp2v_e      crypt;
    aes_ciph_pkg::ciph_op_e op;
    aes_ciph_pkg::key_len_e key_len;
    logic                   alert_fatal;
    logic                   rst_req;
  } drive_t;

  logic                                 clk;
  logic                                 rst_n;
  drive_t                               drv, nxt;
  aes_sp_pkg::sp2v_e                    in_ready, out_valid, state_we;
  aes_ciph_pkg::state_sel_e             state_sel;
  aes_ciph_pkg::add_rk_sel_e            add_rk_sel;
  aes_ciph_pkg::ciph_op_e               key_expand_op;
  logic [aes_ciph_pkg::RndCtrWidth-1:0] key_expand_round;
  logic                                 alert;

  model_state_e           m_state;
  int unsigned            m_rnd, m_nr;
  aes_ciph_pkg::ciph_op_e m_op;
  int unsigned            errors, checks, delivered;
  logic [31:0]            seed;

  tb_clk_gen #(.Period(Period), .RstCycles(3)) u_clk_gen (
    .rst_req_i ( drv.rst_req ),
    .clk_o     ( clk         ),
    .rst_no    ( rst_n       )
  );

  aes_round_ctrl #(.CiphOpFwdOnly(1'b0)) i_dut (
    .clk_i              ( clk              ),
    .rst_ni             ( rst_n            ),
    .in_valid_i         ( drv.in_valid     ),
    .in_ready_o         ( in_ready         ),
    .out_valid_o        ( out_valid        ),
    .out_ready_i        ( drv.out_ready    ),
    .crypt_i            ( drv.crypt        ),
    .op_i               ( drv.op           ),
    .key_len_i          ( drv.key_len      ),
    .alert_fatal_i      ( drv.alert_fatal  ),
    .alert_o            ( alert            ),
    .state_we_o         ( state_we         ),
    .state_sel_o        ( state_sel        ),
    .add_rk_sel_o       ( add_rk_sel       ),
    .key_expand_op_o    ( key_expand_op    ),
    .key_expand_round_o ( key_expand_round )
  );

  //////////////////////////////////////////////////
  // Random numbers and stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int unsigned rand_below(int unsigned n);
    seed = xorshift32(seed);
    return seed % n;
  endfunction

  function automatic aes_ciph_pkg::ciph_op_e rand_op();
    return rand_below(2) ? aes_ciph_pkg::CIPH_INV : aes_ciph_pkg::CIPH_FWD;
  endfunction

  function automatic aes_ciph_pkg::key_len_e rand_key_len();
    case (rand_below(3))
      0:       return aes_ciph_pkg::AES_128;
      1:       return aes_ciph_pkg::AES_192;
      default: return aes_ciph_pkg::AES_256;
    endcase
  endfunction

  function automatic aes_sp_pkg::sp2v_e illegal_code();
    return rand_below(2) ? aes_sp_pkg::sp2v_e'(2'b00) : aes_sp_pkg::sp2v_e'(2'b11);
  endfunction

  function automatic aes_sp_pkg::sp2v_e to_sp2v(bit b);
    return b ? High : Low;
  endfunction

  // Nr is 10, 12 or 14 by key length
  function automatic int unsigned rounds_for(aes_ciph_pkg::key_len_e kl);
    case (kl)
      aes_ciph_pkg::AES_128: return 10;
      aes_ciph_pkg::AES_192: return 12;
      default:               return 14;
    endcase
  endfunction

  function automatic bit is_legal(aes_sp_pkg::sp2v_e v);
    return (v === High) || (v === Low);
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic model_reset();
    m_state = M_IDLE;
    m_rnd   = 0;
    m_nr    = 10;
    m_op    = aes_ciph_pkg::CIPH_FWD;
  endtask

  // One clock edge on the inputs applied before it
  task automatic model_step();
    bit fault;
    fault = !is_legal(drv.in_valid) || !is_legal(drv.out_ready) ||
            !is_legal(drv.crypt) || drv.alert_fatal;
    case (m_state)
      M_IDLE: begin
        if (drv.in_valid == High && drv.crypt == High) begin
          m_state = M_INIT;
          m_rnd   = 0;
          m_op    = drv.op;
          m_nr    = rounds_for(drv.key_len);
        end
      end
      M_INIT: begin
        m_state = M_ROUND;
        m_rnd   = 1;
      end
      M_ROUND: begin
        if (m_rnd == m_nr) m_state = M_DONE;
        else m_rnd++;
      end
      M_DONE: begin
        if (drv.out_ready == High) begin
          m_state = M_IDLE;
          m_rnd   = 0;
        end
      end
      default: m_state = M_ERROR;
    endcase
    if (fault) begin
      m_state = M_ERROR; // Locked until reset
      m_rnd   = 0;
    end
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error: %s expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_outputs();
    aes_ciph_pkg::state_sel_e  exp_sel;
    aes_ciph_pkg::add_rk_sel_e exp_rk;
    exp_sel = aes_ciph_pkg::STATE_INIT;
    exp_rk  = aes_ciph_pkg::ADD_RK_INIT;
    if (m_state == M_ROUND || m_state == M_DONE) begin
      exp_sel = aes_ciph_pkg::STATE_ROUND;
      exp_rk  = (m_rnd == m_nr) ? aes_ciph_pkg::ADD_RK_FINAL : aes_ciph_pkg::ADD_RK_ROUND;
    end
    check_value("in_ready_o", to_sp2v(m_state == M_IDLE), in_ready);
    check_value("out_valid_o", to_sp2v(m_state == M_DONE), out_valid);
    check_value("state_we_o", to_sp2v(m_state inside {M_INIT, M_ROUND}), state_we);
    check_value("state_sel_o", exp_sel, state_sel);
    check_value("add_rk_sel_o", exp_rk, add_rk_sel);
    check_value("key_expand_op_o", m_op, key_expand_op);
    check_value("key_expand_round_o", m_rnd, key_expand_round);
    check_value("alert_o", m_state == M_ERROR, alert);
  endtask

  //////////////////////////////////////////////////
  // Cycle driver and test sequences
  //////////////////////////////////////////////////

  // Drive on the rising edge and compare on the falling edge
  task automatic cycle();
    @(posedge clk);
    if (rst_n !== 1'b1) model_reset();
    else model_step();
    drv <= nxt;
    @(negedge clk);
    if (rst_n === 1'b1) begin
      check_outputs();
      // Delivery seen at the DUT ports, it completes on the next edge
      if (out_valid === High && drv.out_ready === High) begin
        delivered++;
      end
    end
  endtask

  task automatic set_idle();
    nxt.in_valid    = Low;
    nxt.out_ready   = Low;
    nxt.crypt       = rand_below(2) ? High : Low;
    nxt.alert_fatal = 1'b0;
    nxt.rst_req     = 1'b0;
  endtask

  task automatic apply_reset();
    set_idle();
    nxt.rst_req = 1'b1;
    cycle();
    nxt.rst_req = 1'b0;
    while (rst_n !== 1'b1) cycle();
  endtask

  task automatic run_block();
    int unsigned gap, no_crypt, hold;
    bit          early;
    gap      = rand_below(4);
    no_crypt = rand_below(4);
    hold     = rand_below(5);
    early    = rand_below(4) == 0;
    set_idle();
    repeat (gap) cycle();
    nxt.in_valid = High; // Valid without crypt starts nothing
    nxt.crypt    = Low;
    repeat (no_crypt) cycle();
    nxt.crypt     = High;
    nxt.op        = rand_op();
    nxt.key_len   = rand_key_len();
    nxt.out_ready = to_sp2v(early);
    cycle();
    while (in_ready === High) cycle();
    nxt.in_valid = Low;
    nxt.op       = rand_op(); // Config is only sampled at acceptance
    nxt.key_len  = rand_key_len();
    while (out_valid !== High) cycle();
    if (!early) repeat (hold) cycle();
    nxt.out_ready = High;
    while (out_valid === High) cycle();
  endtask

  task automatic run_fault();
    int unsigned kind, lead, tail;
    kind = rand_below(4);
    lead = rand_below(9);
    tail = 2 + rand_below(4);
    set_idle();
    nxt.in_valid = High;
    nxt.crypt    = High;
    nxt.op       = rand_op();
    nxt.key_len  = rand_key_len();
    cycle();
    nxt.in_valid = Low;
    repeat (lead) cycle();
    case (kind)
      0:       nxt.in_valid  = illegal_code();
      1:       nxt.out_ready = illegal_code();
      2:       nxt.crypt     = illegal_code();
      default: nxt.alert_fatal = 1'b1;
    endcase
    cycle();
    set_idle();
    nxt.in_valid  = High; // Locked controller must ignore a new request
    nxt.crypt     = High;
    nxt.out_ready = High;
    repeat (tail) cycle();
    apply_reset();
  endtask

  initial begin
    seed      = 32'h7318_edfb;
    errors    = 0;
    checks    = 0;
    delivered = 0;
    model_reset();
    set_idle();
    nxt.op      = aes_ciph_pkg::CIPH_FWD;
    nxt.key_len = aes_ciph_pkg::AES_128;
    drv        <= nxt;
    while (rst_n !== 1'b1) cycle();
    repeat (NumOps) run_block();
    if (delivered != NumOps) begin
      errors++;
      $display("%0d blocks were delivered where %0d were sent", delivered, NumOps);
    end
    repeat (NumFaults) run_fault();
    repeat (3) cycle();
    $display("Run complete: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(Timeout);
    $display("Timeout: run did not finish within %0d time units", Timeout);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
//////////////////////////////////////////////////
// Testbench clock and active-low reset, the reset
// is applied again on a rising request edge
//////////////////////////////////////////////////

`default_nettype none

module tb_clk_gen #(
  parameter int Period    = 20,
  parameter int RstCycles = 3
) (
  input  logic rst_req_i, // Rising edge restarts the reset
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    forever begin
      repeat (RstCycles) @(posedge clk_o);
      rst_no <= 1'b1;
      @(posedge rst_req_i);
      rst_no <= 1'b0; // Asynchronous assert
    end
  end

endmodule

`default_nettype wire
